// File: design/colmix_pkg.sv
//============================
// colour mixer shared types, widths and pipeline latency
//============================
`default_nettype none

package colmix_pkg;

    // address widths
    localparam int PAL_AW  = 9;   // 512 palette entries per bank
    localparam int PRIO_AW = 8;   // 256 entry priority PROM

    // pixel enables from dot in to rgb out
    localparam int PIX_LAT = 2;

    // palette bank data widths
    localparam int PAL_GR_W = 8;  // green nibble over red nibble
    localparam int PAL_B_W  = 4;

    // per dot layer pixels
    typedef struct packed {
        logic [6:0] char_pxl;     // low 4 bits zero means transparent
        logic [7:0] obj_pxl;      // bit 7 feeds the PROM
        logic [7:0] scr_pxl;      // bits 7 and 3..0 feed the PROM
    } layer_pix_t;

    // winning layer code from the PROM
    typedef logic [1:0] prio_t;

    localparam prio_t PRIO_OBJ = 2'd2;
    localparam prio_t PRIO_SCR = 2'd3;  // 0 and 1 both pick char

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // low while blanked
    typedef struct packed {
        logic lvbl;
        logic lhbl;
    } blank_t;

    // cpu side of the palette
    typedef struct packed {
        logic [9:0] addr;         // bit 9 picks the blue bank
        logic [7:0] din;
        logic       wr_n;
        logic       cs;
    } cpu_bus_t;

endpackage

`default_nettype wire

// File: design/delay_line.sv
//============================
// enable gated shift register for any payload type
//============================
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int  STAGES = 1,
    parameter type T      = logic
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic en,       // advance strobe
    input  wire T     din,
    output wire T     dout
);

    T sr [STAGES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sr[i] <= '0;
            end
        end else if (en) begin
            sr[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                sr[i] <= sr[i-1];  // one step per enable
            end
        end
    end

    assign dout = sr[STAGES-1];

endmodule

`default_nettype wire

// File: design/layer_prio.sv
//============================
// stage 1 priority PROM lookup
// registers the winning layer code beside its dot
//============================
`timescale 1ns/1ps
`default_nettype none

module layer_prio #(
    parameter int PRIO_AW = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pxl_cen,
    input  wire colmix_pkg::layer_pix_t layers,
    // PROM programming
    input  wire logic [PRIO_AW-1:0]     prog_addr,
    input  wire colmix_pkg::prio_t      prom_din,
    input  wire logic                   prom_we,
    // to stage 2
    output colmix_pkg::prio_t           sel_prio,
    output wire colmix_pkg::layer_pix_t sel_layers
);

    colmix_pkg::prio_t prom [2**PRIO_AW];  // filled through the programming port

    logic               obj_blank;
    logic               char_blank;
    logic [PRIO_AW-1:0] prom_addr;
    colmix_pkg::prio_t  prom_q;

    // transparent when the colour nibble is zero
    assign obj_blank  = ~|layers.obj_pxl[3:0];
    assign char_blank = ~|layers.char_pxl[3:0];

    // scroll bank, obj bank, both flags, scroll colour
    assign prom_addr = {
        layers.scr_pxl[7],
        layers.obj_pxl[7],
        obj_blank,
        char_blank,
        layers.scr_pxl[3:0]
    };

    // programming write, works without pxl_cen
    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom[prog_addr] <= prom_din;
        end
    end

    assign prom_q = prom[prom_addr];  // async read of current dot

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_prio <= '0;
        end else if (pxl_cen) begin
            sel_prio <= prom_q;           // code for the dot before this enable
        end
    end

    // dot pixels held one enable to sit next to sel_prio
    delay_line #(
        .STAGES (1),
        .T      (colmix_pkg::layer_pix_t)
    ) u_hold (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (pxl_cen),
        .din    (layers),
        .dout   (sel_layers)
    );

endmodule

`default_nettype wire

// File: design/pal_lookup.sv
//============================
// stage 2 palette lookup
// two RAM banks, cpu access and blanked rgb
//============================
`timescale 1ns/1ps
`default_nettype none

module pal_lookup #(
    parameter int PAL_AW = 9
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pxl_cen,
    input  wire colmix_pkg::prio_t      sel_prio,
    input  wire colmix_pkg::layer_pix_t sel_layers,
    input  wire colmix_pkg::cpu_bus_t   cpu,
    input  wire colmix_pkg::blank_t     blank_dly,
    output logic [7:0]                  pal_dout,
    output colmix_pkg::rgb_t            rgb
);

    localparam int GR_W = colmix_pkg::PAL_GR_W;
    localparam int B_W  = colmix_pkg::PAL_B_W;

    // palette banks, contents come from the cpu
    logic [GR_W-1:0] pal_gr_mem [2**PAL_AW];
    logic [B_W-1:0]  pal_b_mem  [2**PAL_AW];

    logic [PAL_AW-1:0] pal_addr;
    logic              pal_gr_we;
    logic              pal_b_we;
    logic [7:0]        pal_din;
    logic [GR_W-1:0]   pal_gr;     // sync read data
    logic [B_W-1:0]    pal_b;
    logic              cpu_bank_b; // bank select bit above the index
    logic              cpu_wr;
    logic              bl;

    assign cpu_bank_b = cpu.addr[PAL_AW];
    assign cpu_wr     = cpu.cs && !cpu.wr_n;

    // address mux and write strobes, every clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_addr  <= '0;
            pal_gr_we <= 1'b0;
            pal_b_we  <= 1'b0;
        end else begin
            pal_gr_we <= cpu_wr && !cpu_bank_b;
            pal_b_we  <= cpu_wr &&  cpu_bank_b;
            if (cpu.cs) begin
                pal_addr <= cpu.addr[PAL_AW-1:0];  // cpu steals the palette
            end else begin
                case (sel_prio)
                    colmix_pkg::PRIO_OBJ: pal_addr <= {2'b01, sel_layers.obj_pxl[6:0]};
                    colmix_pkg::PRIO_SCR: pal_addr <= {2'b10, sel_layers.scr_pxl[6:0]};
                    default:              pal_addr <= {2'b00, sel_layers.char_pxl};
                endcase
            end
        end
    end

    // write data lines up with the registered strobes
    always_ff @(posedge clk) begin
        pal_din <= cpu.din;
    end

    // green/red bank
    always_ff @(posedge clk) begin
        if (pal_gr_we) begin
            pal_gr_mem[pal_addr] <= pal_din;
        end
        pal_gr <= pal_gr_mem[pal_addr];
    end

    // blue bank, low nibble of the bus only
    always_ff @(posedge clk) begin
        if (pal_b_we) begin
            pal_b_mem[pal_addr] <= pal_din[B_W-1:0];
        end
        pal_b <= pal_b_mem[pal_addr];
    end

    // cpu read back, blue reads with upper nibble set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_dout <= '0;
        end else begin
            pal_dout <= cpu_bank_b ? {4'hf, pal_b} : pal_gr;
        end
    end

    // either level low means blanked
    assign bl = ~blank_dly.lvbl | ~blank_dly.lhbl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (bl) begin
                rgb <= '0;                 // force black
            end else begin
                rgb.red   <= pal_gr[3:0];
                rgb.green <= pal_gr[7:4];
                rgb.blue  <= pal_b;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/colmix_top.sv
//============================
// colour mixer top, priority then palette
//============================
`timescale 1ns/1ps
`default_nettype none

module colmix_top #(
    parameter int PAL_AW  = colmix_pkg::PAL_AW,
    parameter int PRIO_AW = colmix_pkg::PRIO_AW,
    parameter int PIX_LAT = colmix_pkg::PIX_LAT
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pxl_cen,
    // layer pixels
    input  wire colmix_pkg::layer_pix_t layers,
    // video blanking, high while blanked
    input  wire logic                   vbl,
    input  wire logic                   hbl,
    // cpu palette port
    input  wire colmix_pkg::cpu_bus_t   cpu,
    output wire logic [7:0]             pal_dout,
    // PROM programming
    input  wire logic [PRIO_AW-1:0]     prog_addr,
    input  wire colmix_pkg::prio_t      prom_din,
    input  wire logic                   prom_we,
    // video out
    output wire colmix_pkg::rgb_t       rgb,
    output wire colmix_pkg::blank_t     blank_dly
);

    wire colmix_pkg::prio_t      sel_prio;
    wire colmix_pkg::layer_pix_t sel_layers;

    layer_prio #(
        .PRIO_AW    (PRIO_AW)
    ) u_prio (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .layers     (layers),
        .prog_addr  (prog_addr),
        .prom_din   (prom_din),
        .prom_we    (prom_we),
        .sel_prio   (sel_prio),
        .sel_layers (sel_layers)
    );

    pal_lookup #(
        .PAL_AW     (PAL_AW)
    ) u_pal (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .sel_prio   (sel_prio),
        .sel_layers (sel_layers),
        .cpu        (cpu),
        .blank_dly  (blank_dly),
        .pal_dout   (pal_dout),
        .rgb        (rgb)
    );

    // levels go active low and follow the pixel path
    delay_line #(
        .STAGES     (PIX_LAT),
        .T          (colmix_pkg::blank_t)
    ) u_blank (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (pxl_cen),
        .din        ({~vbl, ~hbl}),  // lvbl, lhbl
        .dout       (blank_dly)
    );

endmodule

`default_nettype wire

// File: testbench/tb_colmix.sv
//==============================
// colour mixer testbench, random dots against a model
//==============================
`timescale 1ns/1ps
`default_nettype none

module tb_colmix;

    localparam int PIX_LAT = colmix_pkg::PIX_LAT;
    localparam int N_RW    = 16;    // cpu write/read pairs
    localparam int N_ACT   = 200;   // active dots
    localparam int N_BLK   = 100;   // dots with random blanking
    localparam int N_REP   = 30;    // dots after the PROM change
    localparam int MAX_CYC = 2 * (N_RW * 5 + 256 + 1024 + (N_ACT + N_BLK + N_REP + 20) * 4);

    typedef struct packed {
        colmix_pkg::layer_pix_t d;
        colmix_pkg::prio_t      code;  // PROM model output at capture
        logic                   vbl;
        logic                   hbl;
        logic                   chk;   // palette stable, rgb checkable
    } dot_rec_t;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   pxl_cen = 1'b0;
    logic [1:0]             cen_cnt = '0;
    colmix_pkg::layer_pix_t layers;
    logic                   vbl;
    logic                   hbl;
    colmix_pkg::cpu_bus_t   cpu;
    logic [7:0]             pal_dout;
    logic [7:0]             prog_addr;
    colmix_pkg::prio_t      prom_din;
    logic                   prom_we;
    colmix_pkg::rgb_t       rgb;
    colmix_pkg::blank_t     blank_dly;

    colmix_pkg::prio_t prom_model [256];
    logic [7:0]        gr_model [512];    // green over red
    logic [3:0]        b_model [512];
    dot_rec_t          rec [PIX_LAT+1];   // rec[i] captured i enables ago
    logic              check_en = 1'b0;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    colmix_top DUT (.*);

    always #2 clk = ~clk;

    // one enable every 4 clks
    always @(negedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        pxl_cen <= (cen_cnt == 2'd3);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYC) begin
            $display("timeout: run went past %0d clock cycles", MAX_CYC);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // scroll bank, obj bank, obj clear, char clear, scroll colour
    function automatic logic [7:0] prom_index(input colmix_pkg::layer_pix_t d);
        return {d.scr_pxl[7], d.obj_pxl[7], d.obj_pxl[3:0] == 4'h0,
                d.char_pxl[3:0] == 4'h0, d.scr_pxl[3:0]};
    endfunction

    function automatic colmix_pkg::rgb_t ref_rgb(input colmix_pkg::layer_pix_t d,
            input colmix_pkg::prio_t code, input logic blanked);
        logic [8:0]       idx;
        colmix_pkg::rgb_t c;
        if (code == 2'd2) idx = {2'b01, d.obj_pxl[6:0]};        // object
        else if (code == 2'd3) idx = {2'b10, d.scr_pxl[6:0]};   // scroll
        else idx = {2'b00, d.char_pxl};                        // char for 0 and 1
        c.red   = gr_model[idx][3:0];
        c.green = gr_model[idx][7:4];
        c.blue  = b_model[idx];
        return blanked ? '0 : c;
    endfunction

    task automatic make_dot(output colmix_pkg::layer_pix_t d);
        logic [31:0] r;
        r = $urandom;
        d = r[22:0];
        if (r[31:30] == 2'b00) d.char_pxl[3:0] = 4'h0;  // see-through char
        if (r[29:28] == 2'b00) d.obj_pxl[3:0] = 4'h0;
    endtask

    // wait for an enable, then present the next dot
    task automatic drive_dot(input colmix_pkg::layer_pix_t d, input logic v, input logic h);
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);
        @(negedge clk);
        layers = d;
        vbl = v;
        hbl = h;
    endtask

    task automatic cpu_write(input logic [9:0] a, input logic [7:0] data);
        cpu.addr = a;
        cpu.din = data;
        cpu.wr_n = 1'b0;
        cpu.cs = 1'b1;
        if (a[9]) b_model[a[8:0]] = data[3:0];
        else gr_model[a[8:0]] = data;
        @(negedge clk);
        cpu.cs = 1'b0;
        cpu.wr_n = 1'b1;
    endtask

    task automatic cpu_read(input logic [9:0] a);
        logic [7:0] exp;
        exp = a[9] ? {4'hf, b_model[a[8:0]]} : gr_model[a[8:0]];
        cpu.addr = a;
        cpu.wr_n = 1'b1;
        cpu.cs = 1'b1;
        repeat (3) @(negedge clk);  // address reg, RAM, read-back reg
        check_val(pal_dout, exp, "pal_dout");
        cpu.cs = 1'b0;
    endtask

    task automatic prom_write(input logic [7:0] a, input colmix_pkg::prio_t code);
        prog_addr = a;
        prom_din = code;
        prom_we = 1'b1;
        prom_model[a] = code;
        @(negedge clk);
        prom_we = 1'b0;
    endtask

    // record each dot at its enable, check the one PIX_LAT enables back
    always @(posedge clk) begin
        if (rst_n && pxl_cen) begin
            for (int i = PIX_LAT; i > 0; i--) rec[i] = rec[i-1];
            rec[0] = {layers, prom_model[prom_index(layers)], vbl, hbl, check_en};
            @(negedge clk);
            check_val(blank_dly, {~rec[PIX_LAT-1].vbl, ~rec[PIX_LAT-1].hbl}, "blank_dly");
            // rgb register sees the blanking level shown before this enable
            if (rec[PIX_LAT-1].chk && rec[PIX_LAT].chk) begin
                check_val(rgb, ref_rgb(rec[PIX_LAT-1].d, rec[PIX_LAT-1].code,
                          rec[PIX_LAT].vbl | rec[PIX_LAT].hbl), "rgb");
            end
        end
    end

    initial begin
        colmix_pkg::layer_pix_t d;
        logic [9:0]             addrs [N_RW];
        logic [31:0]            r;
        logic [7:0]             pa;
        colmix_pkg::prio_t      code;
        r = $urandom(32'h7daea728);
        layers = '0;
        vbl = 1'b1;
        hbl = 1'b1;
        cpu = '0;
        cpu.wr_n = 1'b1;
        prog_addr = '0;
        prom_din = '0;
        prom_we = 1'b0;
        for (int i = 0; i <= PIX_LAT; i++) rec[i] = {23'd0, 2'd0, 1'b1, 1'b1, 1'b0};
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_val(rgb, 0, "rgb after reset");
        check_val(blank_dly, 0, "blank_dly after reset");
        check_val(pal_dout, 0, "pal_dout after reset");
        for (int i = 0; i < N_RW; i++) begin
            r = $urandom;
            addrs[i] = r[9:0];
            cpu_write(addrs[i], r[17:10]);
        end
        for (int i = 0; i < N_RW; i++) cpu_read(addrs[i]);
        for (int i = 0; i < 256; i++) begin
            r = $urandom;
            prom_write(i[7:0], r[1:0]);
        end
        for (int i = 0; i < 1024; i++) begin
            r = $urandom;
            cpu_write(i[9:0], r[7:0]);  // both banks while blanked
        end
        check_en = 1'b1;
        for (int i = 0; i < N_ACT; i++) begin
            make_dot(d);
            drive_dot(d, 1'b0, 1'b0);
        end
        for (int i = 0; i < N_BLK; i++) begin
            make_dot(d);
            r = $urandom;
            drive_dot(d, r[1:0] == 2'b00, r[3:2] == 2'b00);
        end
        // move one PROM entry to another layer mid run
        make_dot(d);
        pa = prom_index(d);
        code = (prom_model[pa] == 2'd3) ? 2'd2 : 2'd3;
        drive_dot(d, 1'b0, 1'b0);
        drive_dot(d, 1'b0, 1'b0);
        prom_write(pa, code);
        for (int i = 0; i < N_REP; i++) begin
            if (i % 2 == 0) drive_dot(d, 1'b0, 1'b0);
            else begin
                make_dot(d);
                drive_dot(d, 1'b0, 1'b0);
            end
        end
        repeat (PIX_LAT + 2) begin
            make_dot(d);
            drive_dot(d, 1'b0, 1'b0);  // drain
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) $display("SIMULATION PASSED");
        else $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/colmix_pkg.sv
design/delay_line.sv
design/layer_prio.sv
design/pal_lookup.sv
design/colmix_top.sv
testbench/tb_colmix.sv

// File: Bender.yml
package:
  name: colmix

sources:
  # shared types first
  - design/colmix_pkg.sv
  - design/delay_line.sv
  - design/layer_prio.sv
  - design/pal_lookup.sv
  - design/colmix_top.sv
  - target: simulation
    files:
      - testbench/tb_colmix.sv
